// File: flist.f
+incdir+verif
hdl/tlbPkg.sv
hdl/tlbEntryStore.sv
hdl/tlbInvSelect.sv
hdl/tlbSearchPort.sv
hdl/tlbTop.sv
verif/tlbTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the TLB testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tlbTb -f flist.f -o simTlb

output="$(./obj_dir/simTlb)"
echo "$output"

if grep -qx 'All tests passed!' <<< "$output"; then
  exit 0
fi
exit 1

// File: verif/tlbModel.svh
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

//////////////////////////////
// reference model
//////////////////////////////

// mirror of the entry array, updated in step with the DUT edges
tlbPkg::tlbEntry_t modelEntry [NumEntries];
logic [31:0] rngState = 32'd10652;

// xorshift32
function automatic logic [31:0] nextRand();
  rngState = rngState ^ (rngState << 13);
  rngState = rngState ^ (rngState >> 17);
  rngState = rngState ^ (rngState << 5);
  return rngState;
endfunction

function automatic void modelReset();
  for (int i = 0; i < NumEntries; i++) begin
    modelEntry[i] = '0;
  end
endfunction

function automatic logic invKills(tlbPkg::invReq_t req, tlbPkg::tlbEntry_t e);
  logic       asidEq;
  logic       vaEq;
  logic [2:0] code;
  asidEq = (req.asid == e.asid);
  vaEq   = (req.vppn == e.vppn);
  code   = req.op;
  case (code)
    3'd0, 3'd1: return 1'b1;
    3'd2: return e.isGlobal;
    3'd3: return !e.isGlobal;
    3'd4: return !e.isGlobal && asidEq;
    3'd5: return !e.isGlobal && asidEq && vaEq;
    3'd6: return (e.isGlobal || asidEq) && vaEq;
    default: return 1'b0;  // unused code
  endcase
endfunction

// kills see the table from before the edge and a refill then lands on top
function automatic void modelEdge(logic wEn, logic [IndexWidth-1:0] wIdx,
                                  tlbPkg::tlbEntry_t wEnt, logic iEn, tlbPkg::invReq_t inv);
  if (iEn) begin
    for (int i = 0; i < NumEntries; i++) begin
      if (invKills(inv, modelEntry[i])) begin
        modelEntry[i].exists = 1'b0;
      end
    end
  end
  if (wEn) begin
    modelEntry[wIdx] = wEnt;
  end
endfunction

// expected {found, index, resp}, returns how many entries hit
function automatic int modelSearch(tlbPkg::searchReq_t req, output logic [CheckWidth-1:0] want);
  int                  hits;
  logic                huge;
  logic                tagOk;
  tlbPkg::tlbEntry_t   e;
  tlbPkg::tlbPage_t    pg;
  tlbPkg::searchResp_t resp;
  hits = 0;
  want = '0;
  for (int i = 0; i < NumEntries; i++) begin
    e     = modelEntry[i];
    huge  = (32'(e.ps) > tlbPkg::SmallPageSize);
    tagOk = huge ? (req.vppn[18:10] == e.vppn[18:10]) : (req.vppn == e.vppn);
    if (e.exists && tagOk && (e.isGlobal || (e.asid == req.asid))) begin
      hits++;
      pg         = (huge ? req.vppn[9] : req.vaBit12) ? e.page1 : e.page0;
      resp.ppn   = pg.ppn;
      resp.ps    = e.ps;
      resp.plv   = pg.plv;
      resp.mat   = pg.mat;
      resp.dirty = pg.dirty;
      resp.valid = pg.valid;
      want       = {1'b1, IndexWidth'(i), resp};
    end
  end
  return hits;
endfunction

`endif

// File: verif/tlbTb.sv
`default_nettype none

module tlbTb;

  localparam int NumEntries = 8;
  localparam int IndexWidth = $clog2(NumEntries);
  localparam int CheckWidth = 1 + IndexWidth + $bits(tlbPkg::searchResp_t);

  localparam int ResetCycles = 10;
  localparam int ResetOps    = 16;
  localparam int PageRounds  = 24;
  localparam int AsidRounds  = 16;
  localparam int InvRounds   = 12;
  localparam int TrafficOps  = 200;
  localparam int CollideOps  = 8;
  // cycles per test, summed for the watchdog
  localparam int TotalOps = ResetCycles + ResetOps + 2 * (1 + 2 * PageRounds) +
                            (1 + 4 * AsidRounds) + InvRounds * (NumEntries + 7) +
                            TrafficOps + 2 * CollideOps;

  logic                  clk;
  logic                  rstN;
  tlbPkg::searchReq_t    instReq;
  tlbPkg::searchReq_t    dataReq;
  logic                  writeEn;
  logic [IndexWidth-1:0] writeIndex;
  tlbPkg::tlbEntry_t     writeEntry;
  logic                  invEn;
  tlbPkg::invReq_t       invReq;
  logic                  instFound;
  logic                  dataFound;
  logic [IndexWidth-1:0] instIndex;
  logic [IndexWidth-1:0] dataIndex;
  tlbPkg::searchResp_t   instResp;
  tlbPkg::searchResp_t   dataResp;

  int checks = 0;
  int errors = 0;
  int testChecks = 0;
  int testErrors = 0;
  int testsRun = 0;
  int testsFailed = 0;

  `include "tlbModel.svh"

  tlbTop #(.NumEntries(NumEntries)) DUT (
    .clk          (clk),
    .rstN_i       (rstN),
    .instReq_i    (instReq),
    .dataReq_i    (dataReq),
    .writeEn_i    (writeEn),
    .writeIndex_i (writeIndex),
    .writeEntry_i (writeEntry),
    .invEn_i      (invEn),
    .invReq_i     (invReq),
    .instFound_o  (instFound),
    .instIndex_o  (instIndex),
    .instResp_o   (instResp),
    .dataFound_o  (dataFound),
    .dataIndex_o  (dataIndex),
    .dataResp_o   (dataResp)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  //////////////////////////////
  // random stimulus
  //////////////////////////////

  // small pool so that tags and huge regions collide
  function automatic logic [tlbPkg::VppnWidth-1:0] randVppn();
    logic [31:0] r;
    r = nextRand();
    return {7'h2A, r[1:0], r[2], 6'd0, r[5:3]};
  endfunction

  function automatic logic [tlbPkg::AsidWidth-1:0] randAsid();
    logic [31:0] r;
    r = nextRand();
    return 10'h100 | 10'(r[1:0]);
  endfunction

  function automatic tlbPkg::tlbEntry_t randEntry(logic huge);
    tlbPkg::tlbEntry_t e;
    logic [31:0]       r;
    r          = nextRand();
    e.exists   = 1'b1;
    e.vppn     = randVppn();
    e.ps       = huge ? 6'd22 : 6'd12;
    e.isGlobal = (r[1:0] == 2'b00);  // about one in four
    e.asid     = randAsid();
    r          = nextRand();
    e.page0    = r[25:0];
    r          = nextRand();
    e.page1    = r[25:0];
    return e;
  endfunction

  function automatic tlbPkg::searchReq_t randReq();
    tlbPkg::searchReq_t q;
    logic [31:0]        r;
    r         = nextRand();
    q.vppn    = randVppn();
    q.vaBit12 = r[0];
    q.asid    = randAsid();
    return q;
  endfunction

  // probe aimed at a table slot, live or killed
  function automatic tlbPkg::searchReq_t aimedReq();
    tlbPkg::searchReq_t q;
    tlbPkg::tlbEntry_t  e;
    logic [31:0]        r;
    r         = nextRand();
    e         = modelEntry[r[2:0]];
    q.vppn    = e.vppn;
    q.vaBit12 = r[3];
    q.asid    = r[4] ? e.asid : randAsid();
    return q;
  endfunction

  function automatic tlbPkg::invReq_t randInv();
    tlbPkg::invReq_t v;
    logic [31:0]     r;
    r      = nextRand();
    v.op   = tlbPkg::invOp_e'(r[2:0]);  // 7 included
    v.asid = randAsid();
    v.vppn = r[3] ? modelEntry[r[6:4]].vppn : randVppn();
    return v;
  endfunction

  //////////////////////////////
  // drive and check
  //////////////////////////////

  task automatic checkPort(string testName, string portName, tlbPkg::searchReq_t req,
                           logic found, logic [IndexWidth-1:0] index,
                           tlbPkg::searchResp_t resp);
    logic [CheckWidth-1:0] want;
    logic [CheckWidth-1:0] got;
    int                    hits;
    hits = modelSearch(req, want);
    got  = {found, index, resp};
    if (hits <= 1) begin  // several hits give an undefined merge
      testChecks++;
      assert (got === want) else begin
        $display("Fail %s (%s port): expected %h, actual %h", testName, portName, want, got);
        testErrors++;
      end
    end
  endtask

  // inputs change 1 after the edge, lookups are sampled 1 later
  task automatic runCycle(string testName, tlbPkg::searchReq_t iReq, tlbPkg::searchReq_t dReq,
                          logic wEn, logic [IndexWidth-1:0] wIdx, tlbPkg::tlbEntry_t wEnt,
                          logic iEn, tlbPkg::invReq_t inv);
    @(posedge clk);
    #1;
    instReq    = iReq;
    dataReq    = dReq;
    writeEn    = wEn;
    writeIndex = wIdx;
    writeEntry = wEnt;
    invEn      = iEn;
    invReq     = inv;
    #1;
    checkPort(testName, "inst", iReq, instFound, instIndex, instResp);
    checkPort(testName, "data", dReq, dataFound, dataIndex, dataResp);
    modelEdge(wEn, wIdx, wEnt, iEn, inv);
  endtask

  task automatic lookCycle(string testName, tlbPkg::searchReq_t iReq, tlbPkg::searchReq_t dReq);
    runCycle(testName, iReq, dReq, 1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic flushTable(string testName);
    runCycle(testName, randReq(), randReq(), 1'b0, '0, '0, 1'b1, '0);  // op 0
  endtask

  task automatic finishTest(string testName);
    testsRun++;
    checks += testChecks;
    errors += testErrors;
    if (testErrors == 0) begin
      $display("test %s passed, %0d checks", testName, testChecks);
    end else begin
      testsFailed++;
      $display("test %s failed, %0d of %0d checks wrong", testName, testErrors, testChecks);
    end
    testChecks = 0;
    testErrors = 0;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    tlbPkg::tlbEntry_t     ent;
    tlbPkg::searchReq_t    qi;
    tlbPkg::searchReq_t    qd;
    logic [IndexWidth-1:0] idx;
    logic [31:0]           r;
    rstN       = 1'b0;
    instReq    = '0;
    dataReq    = '0;
    writeEn    = 1'b0;
    writeIndex = '0;
    writeEntry = '0;
    invEn      = 1'b0;
    invReq     = '0;
    modelReset();
    repeat (ResetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;

    repeat (ResetOps) lookCycle("reset", randReq(), randReq());
    finishTest("reset");

    flushTable("smallPage");
    repeat (PageRounds) begin
      ent = randEntry(1'b0);
      r   = nextRand();
      idx = r[2:0];
      runCycle("smallPage", randReq(), randReq(), 1'b1, idx, ent, 1'b0, '0);
      qi.vppn    = ent.vppn;
      qi.vaBit12 = 1'b0;
      qi.asid    = ent.asid;
      qd         = qi;
      qd.vaBit12 = 1'b1;  // odd half on the data side
      lookCycle("smallPage", qi, qd);
    end
    finishTest("smallPage");

    flushTable("hugePage");
    repeat (PageRounds) begin
      ent = randEntry(1'b1);
      r   = nextRand();
      idx = r[2:0];
      runCycle("hugePage", randReq(), randReq(), 1'b1, idx, ent, 1'b0, '0);
      qi.vppn    = {ent.vppn[18:10], r[12:3]};
      qi.vaBit12 = r[13];
      qi.asid    = ent.asid;
      qd         = qi;
      qd.vppn[9] = ~qi.vppn[9];
      qd.vaBit12 = ~qi.vaBit12;
      lookCycle("hugePage", qi, qd);
    end
    finishTest("hugePage");

    flushTable("asid");
    repeat (AsidRounds) begin
      ent          = randEntry(1'b0);
      ent.isGlobal = 1'b0;
      r            = nextRand();
      idx          = r[2:0];
      runCycle("asid", randReq(), randReq(), 1'b1, idx, ent, 1'b0, '0);
      qd.vppn      = ent.vppn;
      qd.vaBit12   = r[3];
      qd.asid      = ent.asid;
      qi           = qd;
      qi.asid      = ent.asid ^ 10'h200;  // outside the asid pool
      lookCycle("asid", qi, qd);
      ent.isGlobal = 1'b1;
      runCycle("asid", randReq(), randReq(), 1'b1, idx, ent, 1'b0, '0);
      lookCycle("asid", qi, qd);
    end
    finishTest("asid");

    repeat (InvRounds) begin
      for (int i = 0; i < NumEntries; i++) begin
        r = nextRand();
        runCycle("invalidate", aimedReq(), aimedReq(), 1'b1, IndexWidth'(i),
                 randEntry(r[0]), 1'b0, '0);
      end
      runCycle("invalidate", aimedReq(), aimedReq(), 1'b0, '0, '0, 1'b1, randInv());
      repeat (6) lookCycle("invalidate", aimedReq(), aimedReq());
    end
    finishTest("invalidate");

    repeat (TrafficOps) begin
      r = nextRand();
      runCycle("traffic", r[0] ? aimedReq() : randReq(), r[1] ? aimedReq() : randReq(),
               r[2], r[5:3], randEntry(r[6]), r[9:7] == 3'd0, randInv());
    end
    // refill and full flush in one cycle, the refill has to survive
    repeat (CollideOps) begin
      ent = randEntry(1'b0);
      r   = nextRand();
      idx = r[2:0];
      runCycle("traffic", randReq(), randReq(), 1'b1, idx, ent, 1'b1, '0);
      qi.vppn    = ent.vppn;
      qi.vaBit12 = r[3];
      qi.asid    = ent.asid;
      lookCycle("traffic", qi, aimedReq());
    end
    finishTest("traffic");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TotalOps * 4 * 2);
    $display("Run timed out after %0d time units", TotalOps * 4 * 2);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/tlbTop.sv
`default_nettype none

module tlbTop #(
  parameter  int NumEntries = 8,
  localparam int IndexWidth = $clog2(NumEntries)
) (
  input  wire                    clk,
  input  wire                    rstN_i,

  // lookups
  input  tlbPkg::searchReq_t     instReq_i,
  input  tlbPkg::searchReq_t     dataReq_i,

  // refill
  input  wire                    writeEn_i,
  input  wire [IndexWidth-1:0]   writeIndex_i,
  input  tlbPkg::tlbEntry_t      writeEntry_i,

  // invalidate
  input  wire                    invEn_i,
  input  tlbPkg::invReq_t        invReq_i,

  output logic                   instFound_o,
  output logic [IndexWidth-1:0]  instIndex_o,
  output tlbPkg::searchResp_t    instResp_o,
  output logic                   dataFound_o,
  output logic [IndexWidth-1:0]  dataIndex_o,
  output tlbPkg::searchResp_t    dataResp_o
);

  tlbPkg::tlbEntry_t [NumEntries-1:0] entries;
  logic [NumEntries-1:0] kill;

  tlbEntryStore #(.NumEntries(NumEntries)) uStore (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .writeEn_i    (writeEn_i),
    .writeIndex_i (writeIndex_i),
    .writeEntry_i (writeEntry_i),
    .kill_i       (kill),
    .entries_o    (entries)
  );

  //////////////////////////////
  // invalidate, one per entry
  //////////////////////////////

  for (genvar e = 0; e < NumEntries; e++) begin : gInv
    tlbInvSelect uInvSel (
      .invEn_i  (invEn_i),
      .invReq_i (invReq_i),
      .entry_i  (entries[e]),
      .kill_o   (kill[e])
    );
  end

  //////////////////////////////
  // search ports
  //////////////////////////////

  tlbSearchPort #(.NumEntries(NumEntries)) uInstPort (  // fetch side
    .entries_i (entries),
    .req_i     (instReq_i),
    .found_o   (instFound_o),
    .index_o   (instIndex_o),
    .resp_o    (instResp_o)
  );

  tlbSearchPort #(.NumEntries(NumEntries)) uDataPort (  // load/store side
    .entries_i (entries),
    .req_i     (dataReq_i),
    .found_o   (dataFound_o),
    .index_o   (dataIndex_o),
    .resp_o    (dataResp_o)
  );

endmodule

`default_nettype wire

// File: hdl/tlbSearchPort.sv
`default_nettype none

module tlbSearchPort #(
  parameter  int NumEntries = 8,
  localparam int IndexWidth = $clog2(NumEntries)
) (
  input  tlbPkg::tlbEntry_t [NumEntries-1:0]  entries_i,
  input  tlbPkg::searchReq_t                  req_i,

  output logic                                found_o,
  output logic [IndexWidth-1:0]               index_o,
  output tlbPkg::searchResp_t                 resp_o
);

  localparam int RespBits = $bits(tlbPkg::searchResp_t);
  localparam int TagHigh  = tlbPkg::VppnWidth - 1;

  logic [NumEntries-1:0] hit;
  tlbPkg::searchResp_t [NumEntries-1:0] cand;  // per-entry result before masking

  //////////////////////////////
  // per-entry compare
  //////////////////////////////

  for (genvar e = 0; e < NumEntries; e++) begin : gEntry
    tlbPkg::tlbEntry_t ent;
    tlbPkg::tlbPage_t  page;
    logic              huge;
    logic              tagMatch;
    logic              asidOk;
    logic              odd;

    assign ent  = entries_i[e];
    assign huge = (ent.ps > tlbPkg::SmallPageSize);

    // huge pages ignore the low vppn bits
    assign tagMatch = huge ?
        (req_i.vppn[TagHigh:tlbPkg::HugeTagLow] == ent.vppn[TagHigh:tlbPkg::HugeTagLow]) :
        (req_i.vppn == ent.vppn);

    assign asidOk = ent.isGlobal || (ent.asid == req_i.asid);
    assign hit[e] = ent.exists && tagMatch && asidOk;

    // even/odd half select
    assign odd  = huge ? req_i.vppn[tlbPkg::HugeOddBit] : req_i.vaBit12;
    assign page = odd ? ent.page1 : ent.page0;

    assign cand[e] = '{
      ppn:   page.ppn,
      ps:    ent.ps,
      plv:   page.plv,
      mat:   page.mat,
      dirty: page.dirty,
      valid: page.valid
    };
  end

  //////////////////////////////
  // and-or merge
  //////////////////////////////

  // several hits OR together, no hit leaves all zeros
  always_comb begin
    index_o = '0;
    resp_o  = '0;
    for (int i = 0; i < NumEntries; i++) begin
      index_o = index_o | ({IndexWidth{hit[i]}} & IndexWidth'(i));
      resp_o  = resp_o | ({RespBits{hit[i]}} & cand[i]);
    end
  end

  assign found_o = |hit;

endmodule

`default_nettype wire

// File: hdl/tlbInvSelect.sv
`default_nettype none

module tlbInvSelect (
  input  wire                 invEn_i,
  input  tlbPkg::invReq_t     invReq_i,
  input  tlbPkg::tlbEntry_t   entry_i,
  output logic                kill_o
);

  logic asidHit;
  logic vppnHit;
  logic killReq;

  assign asidHit = (entry_i.asid == invReq_i.asid);
  assign vppnHit = (entry_i.vppn == invReq_i.vppn);  // full vppn, no huge-page masking

  //////////////////////////////
  // opcode decode
  //////////////////////////////

  always_comb begin
    case (invReq_i.op)
      tlbPkg::InvAll0,
      tlbPkg::InvAll1: begin
        killReq = 1'b1;  // flush everything
      end
      tlbPkg::InvGlobal: begin
        killReq = entry_i.isGlobal;
      end
      tlbPkg::InvNonGlobal: begin
        killReq = !entry_i.isGlobal;
      end
      tlbPkg::InvAsid: begin
        killReq = !entry_i.isGlobal && asidHit;
      end
      tlbPkg::InvAsidVa: begin
        killReq = !entry_i.isGlobal && asidHit && vppnHit;
      end
      tlbPkg::InvGlobalOrAsidVa: begin
        // global pages go regardless of asid here
        killReq = (entry_i.isGlobal || asidHit) && vppnHit;
      end
      default: begin
        killReq = 1'b0;  // code 7
      end
    endcase
  end

  assign kill_o = invEn_i && killReq;

endmodule

`default_nettype wire

// File: hdl/tlbEntryStore.sv
`default_nettype none

module tlbEntryStore #(
  parameter  int NumEntries = 8,
  localparam int IndexWidth = $clog2(NumEntries)
) (
  input  wire                                    clk,
  input  wire                                    rstN_i,

  // refill
  input  wire                                    writeEn_i,
  input  wire        [IndexWidth-1:0]            writeIndex_i,
  input  tlbPkg::tlbEntry_t                      writeEntry_i,

  // one kill bit per entry from the invalidate selectors
  input  wire        [NumEntries-1:0]            kill_i,

  output tlbPkg::tlbEntry_t [NumEntries-1:0]     entries_o
);

  //////////////////////////////
  // storage
  //////////////////////////////

  // exists bits are the only state cleared by reset
  logic [NumEntries-1:0] existsQ;
  tlbPkg::tlbEntry_t [NumEntries-1:0] entryQ;

  logic [NumEntries-1:0] writeSel;  // one-hot write decode

  always_comb begin
    writeSel = '0;
    for (int i = 0; i < NumEntries; i++) begin
      if (writeEn_i && (writeIndex_i == IndexWidth'(i))) begin
        writeSel[i] = 1'b1;
      end
    end
  end

  //////////////////////////////
  // exists bits
  //////////////////////////////

  // a refill beats a kill on the same entry in the same cycle
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      existsQ <= '0;
    end else begin
      for (int i = 0; i < NumEntries; i++) begin
        if (writeSel[i]) begin
          existsQ[i] <= writeEntry_i.exists;
        end else if (kill_i[i]) begin
          existsQ[i] <= 1'b0;
        end
      end
    end
  end

  // payload, only written on refill
  always_ff @(posedge clk) begin
    for (int i = 0; i < NumEntries; i++) begin
      if (writeSel[i]) begin
        entryQ[i] <= writeEntry_i;
      end
    end
  end

  //////////////////////////////
  // read out
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NumEntries; i++) begin
      entries_o[i]        = entryQ[i];
      entries_o[i].exists = existsQ[i];  // reset-cleared copy wins
    end
  end

endmodule

`default_nettype wire

// File: hdl/tlbPkg.sv
`default_nettype none

package tlbPkg;

  //////////////////////////////
  // field widths
  //////////////////////////////

  localparam int VppnWidth = 19;  // va[31:13]
  localparam int AsidWidth = 10;
  localparam int PpnWidth  = 20;
  localparam int PsWidth   = 6;
  localparam int PlvWidth  = 2;
  localparam int MatWidth  = 2;

  // page size 12 is a 4 KiB page, anything above it is huge
  localparam int unsigned SmallPageSize = 12;

  localparam int HugeTagLow = 10;  // huge pages compare vppn[18:10]
  localparam int HugeOddBit = 9;   // picks odd half of a huge page

  //////////////////////////////
  // invalidate codes
  //////////////////////////////

  // code 7 is left undefined and kills nothing
  typedef enum logic [2:0] {
    InvAll0           = 3'd0,
    InvAll1           = 3'd1,
    InvGlobal         = 3'd2,
    InvNonGlobal      = 3'd3,
    InvAsid           = 3'd4,
    InvAsidVa         = 3'd5,
    InvGlobalOrAsidVa = 3'd6
  } invOp_e;

  //////////////////////////////
  // structs
  //////////////////////////////

  // one physical half of an entry
  typedef struct packed {
    logic [PpnWidth-1:0] ppn;
    logic [PlvWidth-1:0] plv;
    logic [MatWidth-1:0] mat;
    logic                dirty;
    logic                valid;
  } tlbPage_t;

  typedef struct packed {
    logic                 exists;
    logic [VppnWidth-1:0] vppn;
    logic [PsWidth-1:0]   ps;
    logic                 isGlobal;
    logic [AsidWidth-1:0] asid;
    tlbPage_t             page0;  // even page
    tlbPage_t             page1;  // odd page
  } tlbEntry_t;

  typedef struct packed {
    logic [VppnWidth-1:0] vppn;
    logic                 vaBit12;
    logic [AsidWidth-1:0] asid;
  } searchReq_t;

  typedef struct packed {
    logic [PpnWidth-1:0] ppn;
    logic [PsWidth-1:0]  ps;
    logic [PlvWidth-1:0] plv;
    logic [MatWidth-1:0] mat;
    logic                dirty;
    logic                valid;
  } searchResp_t;

  typedef struct packed {
    invOp_e               op;
    logic [AsidWidth-1:0] asid;
    logic [VppnWidth-1:0] vppn;
  } invReq_t;

endpackage

`default_nettype wire
